/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := capture_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, the simulator exit code is not used
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/capture_pkg.sv */
`default_nettype none

package capture_pkg;

  // pixel word width of the 9-bit sensor bus
  localparam int pixel_bits = 9;

  localparam int fifo_abits = 4;   // 16 words so the fifo fills and overflows

  localparam int tick_div   = 3;   // system clocks per pixel strobe

  localparam int h_active   = 10;  // visible pixels per line
  localparam int h_total    = 14;  // visible plus horizontal blank

  localparam int v_active   = 4;   // visible lines per frame
  localparam int v_total    = 6;   // visible plus vertical blank

endpackage

`default_nettype wire

/* source/capture_top.sv */
`default_nettype none

module capture_top
  import capture_pkg::*;
#(
  parameter int pixel_bits = capture_pkg::pixel_bits,
  parameter int fifo_abits = capture_pkg::fifo_abits,
  parameter int tick_div   = capture_pkg::tick_div,
  parameter int h_active   = capture_pkg::h_active,
  parameter int h_total    = capture_pkg::h_total,
  parameter int v_active   = capture_pkg::v_active,
  parameter int v_total    = capture_pkg::v_total
)
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  enable,       // lets the pattern advance
  input  logic                  read,         // fifo pop strobe
  output logic                  pixel_tick,
  output logic                  href,
  output logic                  vsync,
  output logic [pixel_bits-1:0] dout,
  output logic                  empty,
  output logic                  full,
  output logic                  overflow
);

  logic                  write;        // one pixel inside the active window
  logic [pixel_bits-1:0] pixel_data;

  assign write = pixel_tick & href & ~vsync;

  sync_timing_gen #(
    .tick_div (tick_div),
    .h_active (h_active),
    .h_total  (h_total),
    .v_active (v_active),
    .v_total  (v_total)
  ) sync_timing_gen_inst (
    .clock      (clock),
    .reset      (reset),
    .pixel_tick (pixel_tick),
    .href       (href),
    .vsync      (vsync)
  );

  pattern_source #(
    .pixel_bits (pixel_bits)
  ) pattern_source_inst (
    .clock      (clock),
    .reset      (reset),
    .write      (write),
    .full       (full),           // no back-pressure, full only stops the count
    .vsync      (vsync),
    .enable     (enable),
    .pixel_data (pixel_data)
  );

  frame_fifo #(
    .pixel_bits (pixel_bits),
    .fifo_abits (fifo_abits)
  ) frame_fifo_inst (
    .clock    (clock),
    .reset    (reset),
    .write    (write),
    .din      (pixel_data),
    .read     (read),
    .dout     (dout),
    .empty    (empty),
    .full     (full),
    .overflow (overflow)
  );

endmodule

`default_nettype wire

/* source/frame_fifo.sv */
`default_nettype none

module frame_fifo
  import capture_pkg::*;
#(
  parameter int pixel_bits = capture_pkg::pixel_bits,
  parameter int fifo_abits = capture_pkg::fifo_abits
)
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  write,      // store din this cycle
  input  logic [pixel_bits-1:0] din,
  input  logic                  read,       // pop oldest word into dout
  output logic [pixel_bits-1:0] dout,       // holds until the next accepted read
  output logic                  empty,
  output logic                  full,
  output logic                  overflow    // sticky flag for a dropped write
);

  localparam int depth = 1 << fifo_abits;   // number of words

  logic [pixel_bits-1:0] mem [depth];       // pixel storage
  logic [fifo_abits-1:0] wr_ptr;            // next slot to write
  logic [fifo_abits-1:0] rd_ptr;            // oldest stored slot
  logic [fifo_abits:0]   count;             // words held with one extra bit to reach depth
  logic [fifo_abits:0]   count_next;
  logic                  rd_accept;
  logic                  wr_accept;

  assign rd_accept = read & ~empty;                 // read on empty is ignored
  assign wr_accept = write & (~full | rd_accept);   // a pop frees the slot

  always_ff @(posedge clock)
  begin
    if (wr_accept)
      mem[wr_ptr] <= din;
  end

  // occupancy after this edge
  always_comb
  begin
    case ({wr_accept, rd_accept})
      2'b10:   count_next = count + (fifo_abits + 1)'(1);   // push only
      2'b01:   count_next = count - (fifo_abits + 1)'(1);   // pop only
      default: count_next = count;                          // idle or both
    endcase
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      empty    <= 1'b1;
      full     <= 1'b0;
      overflow <= 1'b0;
    end
    else
    begin
      if (wr_accept)
        wr_ptr <= wr_ptr + fifo_abits'(1);   // wraps with the address width
      if (rd_accept)
        rd_ptr <= rd_ptr + fifo_abits'(1);
      count <= count_next;
      empty <= (count_next == '0);
      full  <= (count_next == (fifo_abits + 1)'(depth));
      if (write & ~wr_accept)
        overflow <= 1'b1;                    // stays set until reset
    end
  end

  // read word register keeps the old word when a same-edge write hits this slot
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      dout <= '0;
    else if (rd_accept)
      dout <= mem[rd_ptr];
  end

endmodule

`default_nettype wire

/* source/pattern_source.sv */
`default_nettype none

module pattern_source
  import capture_pkg::*;
#(
  parameter int pixel_bits = capture_pkg::pixel_bits
)
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  write,       // pixel strobe inside the active window
  input  logic                  full,        // fifo cannot take the pixel
  input  logic                  vsync,       // vertical blank, restarts the pattern
  input  logic                  enable,      // low freezes the value
  output logic [pixel_bits-1:0] pixel_data   // value offered to the fifo
);

  logic advance;   // pixel taken and pattern allowed to move

  assign advance = write & ~full & enable;

  // running count per frame, wraps at the word width
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      pixel_data <= '0;
    end
    else if (vsync)
    begin
      pixel_data <= '0;                                // every frame starts from zero
    end
    else if (advance)
    begin
      pixel_data <= pixel_data + pixel_bits'(1);
    end
    // with enable low the same value is offered again
  end

endmodule

`default_nettype wire

/* source/sync_timing_gen.sv */
`default_nettype none

module sync_timing_gen
  import capture_pkg::*;
#(
  parameter int tick_div = capture_pkg::tick_div,
  parameter int h_active = capture_pkg::h_active,
  parameter int h_total  = capture_pkg::h_total,
  parameter int v_active = capture_pkg::v_active,
  parameter int v_total  = capture_pkg::v_total
)
(
  input  logic clock,
  input  logic reset,
  output logic pixel_tick,   // one clock wide, once per tick_div clocks
  output logic href,         // line valid level
  output logic vsync         // frame blank level
);

  // counter widths, kept at least one bit for degenerate settings
  localparam int div_w = (tick_div > 1) ? $clog2(tick_div) : 1;
  localparam int col_w = (h_total > 1) ? $clog2(h_total) : 1;
  localparam int row_w = (v_total > 1) ? $clog2(v_total) : 1;

  logic [div_w-1:0] div_cnt;    // position inside one pixel period
  logic [div_w-1:0] div_next;
  logic [col_w-1:0] col;        // pixel column within the line
  logic [col_w-1:0] col_next;
  logic [row_w-1:0] row;        // line number within the frame
  logic [row_w-1:0] row_next;
  logic             col_wrap;   // at the last column of the line
  logic             row_wrap;   // at the last line of the frame

  assign col_wrap = (col == col_w'(h_total - 1));
  assign row_wrap = (row == row_w'(v_total - 1));

  // clock divider, free running
  always_comb
  begin
    if (div_cnt == div_w'(tick_div - 1))
      div_next = '0;            // wrap, new pixel period starts
    else
      div_next = div_cnt + div_w'(1);
  end

  // column and row only move at the edge that closes a tick cycle
  always_comb
  begin
    col_next = col;
    row_next = row;
    if (pixel_tick)
    begin
      if (col_wrap)
      begin
        col_next = '0;          // end of line
        if (row_wrap)
          row_next = '0;        // end of frame
        else
          row_next = row + row_w'(1);
      end
      else
      begin
        col_next = col + col_w'(1);
      end
    end
  end

  // outputs decode the next counter values so all three switch on one edge
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      div_cnt    <= '0;
      col        <= '0;
      row        <= '0;
      pixel_tick <= 1'b0;
      href       <= 1'b1;       // column 0 is inside the active line
      vsync      <= 1'b0;       // row 0 is inside the active frame
    end
    else
    begin
      div_cnt    <= div_next;
      col        <= col_next;
      row        <= row_next;
      pixel_tick <= (div_next == div_w'(tick_div - 1));
      href       <= (int'(col_next) < h_active);
      vsync      <= (int'(row_next) >= v_active);   // blank lines sit at the end
    end
  end

endmodule

`default_nettype wire

/* sources.f */
source/capture_pkg.sv
source/sync_timing_gen.sv
source/pattern_source.sv
source/frame_fifo.sv
source/capture_top.sv
verif/capture_tb.sv

/* verif/capture_tb.sv */
`default_nettype none

module capture_tb
  import capture_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int depth = 1 << fifo_abits;   // fifo words

  logic                  clock;
  logic                  reset;
  logic                  enable;
  logic                  read;
  logic                  pixel_tick;
  logic                  href;
  logic                  vsync;
  logic [pixel_bits-1:0] dout;
  logic                  empty;
  logic                  full;
  logic                  overflow;

  integer seed;                              // $random state

  logic [pixel_bits-1:0] exp_q[$];           // pixels the fifo should hold in arrival order
  logic [pixel_bits-1:0] m_pix;              // model pattern value
  logic [pixel_bits-1:0] m_dout;             // model read register
  logic                  m_ovf;              // model sticky overflow
  int                    m_col;
  int                    m_row;
  int                    frames;             // completed frames since reset
  int                    both_at_full;       // write and read on one edge while full
  int                    both_at_empty;      // write and read on one edge while empty
  int                    idle_reads;         // reads that found the fifo empty
  int                    since_tick;         // negedges since the last pixel_tick
  logic                  seen_tick;
  logic                  checks_on;

  capture_top #(
    .pixel_bits (pixel_bits),
    .fifo_abits (fifo_abits),
    .tick_div   (tick_div),
    .h_active   (h_active),
    .h_total    (h_total),
    .v_active   (v_active),
    .v_total    (v_total)
  ) capture_top_inst (
    .clock      (clock),
    .reset      (reset),
    .enable     (enable),
    .read       (read),
    .pixel_tick (pixel_tick),
    .href       (href),
    .vsync      (vsync),
    .dout       (dout),
    .empty      (empty),
    .full       (full),
    .overflow   (overflow)
  );

  initial
  begin
    clock = 1'b0;
    forever #4 clock = ~clock;   // 8 ns period
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(input string what, input int got, input int want);
    fail_now($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, what, got, want));
  endtask

  // true with a chance of level in 8
  function automatic logic chance8(input int level);
    return (($random(seed) & 7) < level);
  endfunction

  // applies the fifo, pattern and timing rules to the values seen before this edge
  task automatic step_model();
    logic wr;
    logic rd_ok;
    logic wr_ok;
    logic was_full;
    int   held;
    held     = exp_q.size();
    was_full = (held == depth);
    wr       = pixel_tick & href & ~vsync;       // write strobe of the top level
    rd_ok    = read & (held != 0);
    wr_ok    = wr & (!was_full | rd_ok);         // a pop makes room at full
    if (wr && read && was_full)
      both_at_full++;
    if (wr && read && held == 0)
      both_at_empty++;
    if (read && held == 0)
      idle_reads++;
    if (rd_ok)
      m_dout = exp_q.pop_front();                // pop before push so a same-edge push lands behind
    if (wr_ok)
      exp_q.push_back(m_pix);
    if (wr && !wr_ok)
      m_ovf = 1'b1;
    if (vsync)
      m_pix = '0;                                // restart during vertical blank
    else if (wr && !was_full && enable)
      m_pix = m_pix + pixel_bits'(1);
    if (pixel_tick)
    begin
      if (m_col == h_total - 1)
      begin
        m_col = 0;
        if (m_row == v_total - 1)
        begin
          m_row = 0;
          frames++;
        end
        else
          m_row++;
      end
      else
        m_col++;
    end
  endtask

  task automatic clear_model();
    exp_q.delete();
    m_pix         = '0;
    m_dout        = '0;
    m_ovf         = 1'b0;
    m_col         = 0;
    m_row         = 0;
    frames        = 0;
    both_at_full  = 0;
    both_at_empty = 0;
    idle_reads    = 0;
  endtask

  always @(posedge clock)
  begin
    if (reset)
      clear_model();
    else
      step_model();
  end

  // outputs are stable at the falling edge
  task automatic check_outputs();
    since_tick++;
    if (pixel_tick)
    begin
      if (seen_tick)
      begin
        assert (since_tick == tick_div)
        else value_error("pixel_tick spacing", since_tick, tick_div);
      end
      since_tick = 0;
      seen_tick  = 1'b1;
    end
    else
    begin
      assert (since_tick < tick_div)
      else value_error("cycles without pixel_tick", since_tick, tick_div - 1);
    end
    assert (href == (m_col < h_active))
    else value_error("href", int'(href), int'(m_col < h_active));
    assert (vsync == (m_row >= v_active))
    else value_error("vsync", int'(vsync), int'(m_row >= v_active));
    assert (dout == m_dout)
    else value_error("dout", int'(dout), int'(m_dout));
    assert (empty == (exp_q.size() == 0))
    else value_error("empty", int'(empty), int'(exp_q.size() == 0));
    assert (full == (exp_q.size() == depth))
    else value_error("full", int'(full), int'(exp_q.size() == depth));
    assert (overflow == m_ovf)
    else value_error("overflow", int'(overflow), int'(m_ovf));
  endtask

  always @(negedge clock)
  begin
    if (checks_on)
      check_outputs();
    else
    begin
      since_tick = 0;
      seen_tick  = 1'b0;
    end
  end

  task automatic check_reset_state();
    assert (empty == 1'b1) else value_error("empty after reset", int'(empty), 1);
    assert (full == 1'b0) else value_error("full after reset", int'(full), 0);
    assert (overflow == 1'b0) else value_error("overflow after reset", int'(overflow), 0);
    assert (dout == '0) else value_error("dout after reset", int'(dout), 0);
    assert (href == 1'b1) else value_error("href after reset", int'(href), 1);
    assert (vsync == 1'b0) else value_error("vsync after reset", int'(vsync), 0);
    assert (pixel_tick == 1'b0) else value_error("pixel_tick after reset", int'(pixel_tick), 0);
  endtask

  task automatic run_traffic(input int cycles, input int read_level);
    repeat (cycles)
    begin
      @(negedge clock);
      enable = chance8(7);          // mostly high
      read   = chance8(read_level);
    end
  endtask

  task automatic fill_until_full(input int limit);
    int n;
    n    = 0;
    read = 1'b0;
    while (!full)
    begin
      if (n == limit)
        fail_now("timeout: the fifo never became full with reads stopped");
      @(negedge clock);
      enable = chance8(7);
      n++;
    end
  endtask

  task automatic wait_overflow(input int limit);
    int n;
    n    = 0;
    read = 1'b0;
    while (!overflow)
    begin
      if (n == limit)
        fail_now("timeout: overflow never rose while the fifo stayed full");
      @(negedge clock);
      enable = chance8(7);
      n++;
    end
  endtask

  // read exactly in a write-strobe cycle while full
  task automatic write_read_at_full(input int limit);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done)
    begin
      if (n == limit)
        fail_now("timeout: no write strobe arrived while the fifo was full");
      @(negedge clock);
      enable = chance8(7);
      read   = full & pixel_tick & href & ~vsync;
      done   = read;
      n++;
    end
    @(negedge clock);
    read = 1'b0;
  endtask

  // drain and then read in a write-strobe cycle while empty
  task automatic write_read_at_empty(input int limit);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done)
    begin
      if (n == limit)
        fail_now("timeout: no write strobe arrived while the fifo was empty");
      @(negedge clock);
      enable = chance8(7);
      if (!empty)
        read = 1'b1;                             // still draining
      else
        read = pixel_tick & href & ~vsync;
      done = empty & read;
      n++;
    end
    @(negedge clock);
    read = 1'b0;
  endtask

  initial
  begin
    seed      = 96;
    reset     = 1'b1;
    enable    = 1'b0;
    read      = 1'b0;
    checks_on = 1'b0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_reset_state();
    @(posedge clock);
    checks_on = 1'b1;

    run_traffic(400, 2);             // light reads leave the fifo partly filled
    fill_until_full(400);
    wait_overflow(300);              // first dropped pixel
    write_read_at_full(300);
    run_traffic(30, 0);
    write_read_at_empty(400);
    run_traffic(500, 4);
    run_traffic(500, 2);
    run_traffic(300, 6);             // mostly draining
    @(negedge clock);
    read = 1'b0;
    #1;                              // after the checks of this falling edge

    if (m_ovf && both_at_full > 0 && both_at_empty > 0 && idle_reads > 0 && frames >= 3)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      fail_now($sformatf("incomplete run: frames %0d, at full %0d, at empty %0d, %s %0d",
                         frames, both_at_full, both_at_empty, "idle reads", idle_reads));
    end
  end

endmodule

`default_nettype wire
